// ==== hw/bcd_down_counter.sv ====
// Four-digit BCD down counter of the countdown timer
// Reloads from the preset, counts down per enabled tick, stops at 0000

`timescale 1ns/1ps

module bcd_down_counter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       tick,
    input  logic                       enable,
    input  logic                       reload,
    input  logic [timer_pkg::TIME_W-1:0] preset,
    output logic [timer_pkg::TIME_W-1:0] count,
    output logic                       expired
);

    import timer_pkg::*;

    // Count minus one in BCD
    logic [TIME_W-1:0] dec_value;
    // Borrow rippling from the LSD upward
    logic              borrow;

    //////////////////////////////
    // BCD subtract one
    //////////////////////////////

    always_comb begin
        dec_value = count;
        borrow    = 1'b1;
        for (int i = 0; i < DIGITS; i++) begin
            if (borrow) begin
                if (count[i*DIGIT_W +: DIGIT_W] == '0) begin
                    // 0 borrows from the next digit and becomes 9
                    dec_value[i*DIGIT_W +: DIGIT_W] = DIGIT_W'(9);
                end else begin
                    dec_value[i*DIGIT_W +: DIGIT_W] = count[i*DIGIT_W +: DIGIT_W] - 1'b1;
                    borrow = 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // Count register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= INIT_PRESET;
        end else if (reload) begin
            count <= preset;
        end else if (enable && tick && !expired) begin
            // Floor at 0000, no wrap to 9999
            count <= dec_value;
        end
    end

    // Expiry straight from the count
    assign expired = (count == '0);

endmodule

// ==== hw/bcd_preset_editor.sv ====
// Preset editor for the countdown timer
// Holds four BCD preset digits and a cursor, adjusts the selected digit

`timescale 1ns/1ps

module bcd_preset_editor (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enter,
    input  logic                         inc,
    input  logic                         dec,
    input  logic                         left,
    input  logic                         right,
    output logic [timer_pkg::TIME_W-1:0]   preset,
    output logic [timer_pkg::CURSOR_W-1:0] cursor
);

    import timer_pkg::*;

    // Digit under the cursor
    logic [DIGIT_W-1:0] sel_digit;
    // Its value after one step up or down
    logic [DIGIT_W-1:0] digit_up;
    logic [DIGIT_W-1:0] digit_down;

    //////////////////////////////
    // Digit arithmetic
    //////////////////////////////

    assign sel_digit = preset[cursor*DIGIT_W +: DIGIT_W];

    always_comb begin
        // Up wraps 9 to 0
        if (sel_digit >= DIGIT_W'(9)) begin
            digit_up = '0;
        end else begin
            digit_up = sel_digit + 1'b1;
        end

        // Down wraps 0 to 9
        if (sel_digit == '0) begin
            digit_down = DIGIT_W'(9);
        end else begin
            digit_down = sel_digit - 1'b1;
        end
    end

    //////////////////////////////
    // Preset and cursor registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            preset <= INIT_PRESET;
            // Start on the most significant digit
            cursor <= CURSOR_W'(DIGITS - 1);
        end else if (enter) begin
            // Entering set mode always starts at the left digit
            cursor <= CURSOR_W'(DIGITS - 1);
        end else if (left) begin
            // Toward the MSD, 3 rolls over to 0
            cursor <= cursor + 1'b1;
        end else if (right) begin
            // Toward the LSD, 0 rolls over to 3
            cursor <= cursor - 1'b1;
        end else if (inc) begin
            preset[cursor*DIGIT_W +: DIGIT_W] <= digit_up;
        end else if (dec) begin
            preset[cursor*DIGIT_W +: DIGIT_W] <= digit_down;
        end
    end

    // Only one command arrives per cycle from the FSM,
    // the order above just fixes the priority if that ever changes

endmodule

// ==== hw/countdown_fsm.sv ====
// Mode FSM of the countdown timer
// Decodes buttons into editor, counter and hold-off commands, drives the alarm

`timescale 1ns/1ps

module countdown_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [timer_pkg::BTN_W-1:0]  button,
    input  logic                        hold_zero,
    input  logic                        expired,
    output logic [timer_pkg::MODE_W-1:0] mode,
    output logic                        beep,
    output logic                        hold_load,
    output logic [timer_pkg::WAIT_W-1:0] hold_value,
    output logic                        enter,
    output logic                        inc,
    output logic                        dec,
    output logic                        left,
    output logic                        right,
    output logic                        reload,
    output logic                        count_en
);

    import timer_pkg::*;

    logic [MODE_W-1:0] state;
    logic [MODE_W-1:0] next_state;

    //////////////////////////////
    // State register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MODE_STOPPED;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // Next state and commands
    //////////////////////////////

    always_comb begin
        // Defaults hold everything still
        next_state = state;
        hold_load  = 1'b0;
        hold_value = WAIT_W'(WAIT_SHORT);
        enter      = 1'b0;
        inc        = 1'b0;
        dec        = 1'b0;
        left       = 1'b0;
        right      = 1'b0;
        reload     = 1'b0;
        count_en   = 1'b0;

        case (state)
            MODE_STOPPED: begin
                if (hold_zero && button[BTN_RUN]) begin
                    next_state = MODE_RUN;
                    hold_load  = 1'b1;
                    hold_value = WAIT_W'(WAIT_LONG);
                end else if (hold_zero && button[BTN_SET]) begin
                    // Cursor back to the MSD on the way in
                    next_state = MODE_SET;
                    enter      = 1'b1;
                    hold_load  = 1'b1;
                end
            end

            MODE_RUN: begin
                count_en = 1'b1;
                // Expiry beats a stop press in the same cycle
                if (expired) begin
                    next_state = MODE_ALARM;
                    hold_load  = 1'b1;
                    hold_value = WAIT_W'(WAIT_ALARM);
                end else if (hold_zero && button[BTN_RUN]) begin
                    next_state = MODE_STOPPED;
                    hold_load  = 1'b1;
                    hold_value = WAIT_W'(WAIT_LONG);
                end
            end

            MODE_SET: begin
                // One action per hold-off window, CLEAR first
                if (hold_zero) begin
                    hold_load = |{button[BTN_CLEAR], button[BTN_EXIT], button[BTN_LEFT],
                                  button[BTN_RIGHT], button[BTN_UP], button[BTN_DOWN]};
                    if (button[BTN_CLEAR]) begin
                        next_state = MODE_STOPPED;
                        reload     = 1'b1;
                    end else if (button[BTN_EXIT]) begin
                        // Leave with the count as it was
                        next_state = MODE_STOPPED;
                    end else if (button[BTN_LEFT]) begin
                        left = 1'b1;
                    end else if (button[BTN_RIGHT]) begin
                        right = 1'b1;
                    end else if (button[BTN_UP]) begin
                        inc = 1'b1;
                    end else if (button[BTN_DOWN]) begin
                        dec = 1'b1;
                    end
                end
            end

            MODE_ALARM: begin
                // A press ends the alarm early and spaces out the next action
                if (button[BTN_RUN] || button[BTN_SET]) begin
                    next_state = MODE_STOPPED;
                    reload     = 1'b1;
                    hold_load  = 1'b1;
                end else if (hold_zero) begin
                    // Alarm time used up
                    next_state = MODE_STOPPED;
                    reload     = 1'b1;
                end
            end

            default: begin
                next_state = MODE_STOPPED;
            end
        endcase
    end

    // Outputs straight from the state
    assign mode = state;
    assign beep = (state == MODE_ALARM);

endmodule

// ==== hw/countdown_timer_top.sv ====
// Four-digit BCD countdown timer with preset editor and alarm
// Ties the mode FSM, hold-off timer, preset editor and down counter together

`timescale 1ns/1ps

module countdown_timer_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          tick,
    input  logic [timer_pkg::BTN_W-1:0]    button,
    output logic [timer_pkg::TIME_W-1:0]   count,
    output logic [timer_pkg::TIME_W-1:0]   preset,
    output logic [timer_pkg::CURSOR_W-1:0] cursor,
    output logic [timer_pkg::MODE_W-1:0]   mode,
    output logic                          beep
);

    import timer_pkg::*;

    //////////////////////////////
    // FSM command and status wires
    //////////////////////////////

    logic              hold_load;
    logic [WAIT_W-1:0] hold_value;
    logic              hold_zero;
    logic              enter;
    logic              inc;
    logic              dec;
    logic              left;
    logic              right;
    logic              reload;
    logic              count_en;
    logic              expired;

    // Mode control
    countdown_fsm countdown_fsm_inst (
        .clk(clk), .reset(reset), .button(button), .hold_zero(hold_zero),
        .expired(expired), .mode(mode), .beep(beep), .hold_load(hold_load),
        .hold_value(hold_value), .enter(enter), .inc(inc), .dec(dec),
        .left(left), .right(right), .reload(reload), .count_en(count_en)
    );

    // Button spacing and alarm length
    hold_off_timer hold_off_timer_inst (
        .clk(clk), .reset(reset), .tick(tick), .load(hold_load),
        .load_value(hold_value), .hold_zero(hold_zero)
    );

    // Preset digits and cursor
    bcd_preset_editor bcd_preset_editor_inst (
        .clk(clk), .reset(reset), .enter(enter), .inc(inc), .dec(dec),
        .left(left), .right(right), .preset(preset), .cursor(cursor)
    );

    // Running count
    bcd_down_counter bcd_down_counter_inst (
        .clk(clk), .reset(reset), .tick(tick), .enable(count_en), .reload(reload),
        .preset(preset), .count(count), .expired(expired)
    );

endmodule

// ==== hw/hold_off_timer.sv ====
// Hold-off timer for button spacing and alarm duration
// Loads a tick count, counts it down and flags zero

`timescale 1ns/1ps

module hold_off_timer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       tick,
    input  logic                       load,
    input  logic [timer_pkg::WAIT_W-1:0] load_value,
    output logic                       hold_zero
);

    import timer_pkg::*;

    // Remaining ticks before the next action is accepted
    logic [WAIT_W-1:0] remaining;

    //////////////////////////////
    // Down counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            // Free to act right after reset
            remaining <= '0;
        end else if (load) begin
            // Load wins over a tick in the same cycle
            remaining <= load_value;
        end else if (tick && !hold_zero) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Sits at zero until the next load
    assign hold_zero = (remaining == '0);

endmodule

// ==== hw/timer_pkg.sv ====
// Shared constants for the four-digit BCD countdown timer
// Widths, hold-off times, button map, mode codes and the power-up preset

package timer_pkg;

    //////////////////////////////
    // Time word layout
    //////////////////////////////

    // Four BCD digits, most significant digit at index 3
    localparam int DIGITS   = 4;
    localparam int DIGIT_W  = 4;
    localparam int TIME_W   = DIGITS * DIGIT_W;
    localparam int CURSOR_W = 2;

    // Preset and count after reset
    localparam logic [TIME_W-1:0] INIT_PRESET = 16'h0325;

    //////////////////////////////
    // Hold-off times in ticks
    //////////////////////////////

    // Spacing after an edit press
    localparam int WAIT_SHORT = 199;
    // Spacing after start or stop
    localparam int WAIT_LONG  = 1999;
    // How long the alarm sounds
    localparam int WAIT_ALARM = 9999;
    // Counter wide enough for the longest wait
    localparam int WAIT_W     = $clog2(WAIT_ALARM + 1);

    //////////////////////////////
    // Buttons
    //////////////////////////////

    localparam int BTN_W     = 8;
    localparam int BTN_SET   = 0;
    localparam int BTN_RUN   = 1;
    localparam int BTN_RIGHT = 2;
    localparam int BTN_LEFT  = 3;
    localparam int BTN_DOWN  = 4;
    localparam int BTN_UP    = 5;
    localparam int BTN_CLEAR = 6;
    localparam int BTN_EXIT  = 7;

    //////////////////////////////
    // Mode codes
    //////////////////////////////

    localparam int MODE_W = 2;
    localparam logic [MODE_W-1:0] MODE_STOPPED = 2'd0;
    localparam logic [MODE_W-1:0] MODE_RUN     = 2'd1;
    localparam logic [MODE_W-1:0] MODE_SET     = 2'd2;
    localparam logic [MODE_W-1:0] MODE_ALARM   = 2'd3;

endpackage

// ==== sim/countdown_timer_checker.sv ====
// Bound assertions on the countdown timer outputs
// Alarm output, preset digit range and count stability in set mode

`timescale 1ns/1ps

module countdown_timer_checker (
    input logic                         clk,
    input logic                         reset,
    input logic [timer_pkg::TIME_W-1:0] count,
    input logic [timer_pkg::TIME_W-1:0] preset,
    input logic [timer_pkg::MODE_W-1:0] mode,
    input logic                         beep
);

    import timer_pkg::*;

    // Every digit of a time word in 0 to 9
    function automatic logic all_bcd(logic [TIME_W-1:0] value);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < DIGITS; i++) begin
            ok = ok && (value[i*DIGIT_W +: DIGIT_W] <= DIGIT_W'(9));
        end
        return ok;
    endfunction

    // Alarm sounds in alarm mode only and only with the count at 0000
    beep_matches_alarm: assert property (@(posedge clk) disable iff (reset)
        (beep == (mode == MODE_ALARM)) && (!beep || count == '0))
        else $error("beep does not follow alarm mode with the count at 0000");

    preset_digits_bcd: assert property (@(posedge clk) disable iff (reset) all_bcd(preset))
        else $error("preset holds a digit above 9");

    // Count frozen while editing except on the exit from set
    count_frozen_in_set: assert property (@(posedge clk) disable iff (reset)
        (mode == MODE_SET) |=> (mode != MODE_SET) || $stable(count))
        else $error("count changed in set mode");

endmodule

// ==== sim/countdown_timer_tb.sv ====
// Testbench for the four-digit BCD countdown timer
// Edits the preset, runs the countdown and ends alarms, checked against a decimal model

`timescale 1ns/1ps

module countdown_timer_tb;

    import timer_pkg::*;

    // Model operations
    localparam int OP_UP    = 0;
    localparam int OP_DOWN  = 1;
    localparam int OP_COUNT = 2;

    logic                clk = 1'b0;
    logic                reset;
    logic                tick;
    logic [BTN_W-1:0]    button;
    logic [TIME_W-1:0]   count;
    logic [TIME_W-1:0]   preset;
    logic [CURSOR_W-1:0] cursor;
    logic [MODE_W-1:0]   mode;
    logic                beep;

    // Model state
    logic [TIME_W-1:0]   ref_preset;
    logic [CURSOR_W-1:0] ref_cursor;
    logic [TIME_W-1:0]   ref_count;
    logic [7:0]          lfsr = 8'd56;
    // Ticks the DUT takes while running
    int                  run_ticks;
    int                  errors;
    int                  test_errors;
    int                  tests;
    string               test_name;

    countdown_timer_top countdown_timer_top_inst (
        .clk(clk), .reset(reset), .tick(tick), .button(button), .count(count),
        .preset(preset), .cursor(cursor), .mode(mode), .beep(beep)
    );

    bind countdown_timer_top countdown_timer_checker countdown_timer_checker_inst (
        .clk(clk), .reset(reset), .count(count), .preset(preset), .mode(mode), .beep(beep)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    //////////////////////////////
    // Model and random source
    //////////////////////////////

    // Fibonacci LFSR x^8+x^6+x^5+x^4+1 stepped once per bit
    function automatic int random_bits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | lfsr[7];
            lfsr  = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
        return value;
    endfunction

    // Digit adjust with wrap or countdown by n with floor at zero in decimal
    function automatic logic [TIME_W-1:0] ref_time(int op, logic [TIME_W-1:0] value,
                                                   int cur, int n);
        int                digit [DIGITS];
        int                total;
        int                weight;
        logic [TIME_W-1:0] result;
        total  = 0;
        weight = 1;
        for (int i = 0; i < DIGITS; i++) begin
            digit[i] = int'(value[i*DIGIT_W +: DIGIT_W]);
            total    = total + digit[i] * weight;
            weight   = weight * 10;
        end
        case (op)
            OP_UP:   digit[cur] = (digit[cur] + 1) % 10;
            OP_DOWN: digit[cur] = (digit[cur] + 9) % 10;
            default: begin
                total = (total > n) ? total - n : 0;
                for (int i = 0; i < DIGITS; i++) begin
                    digit[i] = total % 10;
                    total    = total / 10;
                end
            end
        endcase
        for (int i = 0; i < DIGITS; i++) begin
            result[i*DIGIT_W +: DIGIT_W] = DIGIT_W'(digit[i]);
        end
        return result;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_time(string what, logic [TIME_W-1:0] want, logic [TIME_W-1:0] got);
        if (got !== want) begin
            $display("error: %s %s expected %h actual %h", test_name, what, want, got);
            test_errors++;
        end
    endtask

    task automatic check_mode(string what, logic [MODE_W-1:0] want, logic [MODE_W-1:0] got);
        if (got !== want) begin
            $display("error: %s %s expected %0d actual %0d", test_name, what, want, got);
            test_errors++;
        end
    endtask

    task automatic check_cursor(string what, logic [CURSOR_W-1:0] want,
                                logic [CURSOR_W-1:0] got);
        if (got !== want) begin
            $display("error: %s %s expected %0d actual %0d", test_name, what, want, got);
            test_errors++;
        end
    endtask

    task automatic check_bit(string what, logic want, logic got);
        if (got !== want) begin
            $display("error: %s %s expected %b actual %b", test_name, what, want, got);
            test_errors++;
        end
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Samples on the falling edge
    // A tick seen here in run mode is taken at the next rise
    task automatic next_sample();
        @(negedge clk);
        if (mode == MODE_RUN && tick) begin
            run_ticks++;
        end
    endtask

    // Hold a button (none if negative) until the mode reaches target
    task automatic wait_for_mode(int btn, logic [MODE_W-1:0] target, int limit);
        int waited;
        waited = 0;
        @(posedge clk);
        if (btn >= 0) begin
            button[btn] <= 1'b1;
        end
        while (mode != target && waited < limit) begin
            next_sample();
            waited++;
        end
        if (mode != target) begin
            $display("test %s: mode never reached %0d in %0d cycles", test_name, target, limit);
            test_errors++;
        end
        @(posedge clk);
        button <= '0;
        next_sample();
    endtask

    // Holds one edit press until the preset or cursor moves and compares with the model
    task automatic edit_press(int btn);
        logic [TIME_W-1:0]   old_preset;
        logic [CURSOR_W-1:0] old_cursor;
        int                  waited;
        waited = 0;
        next_sample();
        old_preset = preset;
        old_cursor = cursor;
        @(posedge clk);
        button[btn] <= 1'b1;
        while (preset == old_preset && cursor == old_cursor && waited < 400) begin
            next_sample();
            waited++;
        end
        if (preset == old_preset && cursor == old_cursor) begin
            $display("test %s: button %0d changed nothing in 400 cycles", test_name, btn);
            test_errors++;
        end
        case (btn)
            BTN_UP:   ref_preset = ref_time(OP_UP, ref_preset, ref_cursor, 0);
            BTN_DOWN: ref_preset = ref_time(OP_DOWN, ref_preset, ref_cursor, 0);
            BTN_LEFT: ref_cursor = ref_cursor + 1'b1;
            default:  ref_cursor = ref_cursor - 1'b1;
        endcase
        check_time("preset", ref_preset, preset);
        check_cursor("cursor", ref_cursor, cursor);
        @(posedge clk);
        button <= '0;
    endtask

    // Step the digit under the cursor up to the wanted value
    task automatic dial_digit(int target);
        while (ref_preset[ref_cursor*DIGIT_W +: DIGIT_W] != target) begin
            edit_press(BTN_UP);
        end
    endtask

    task automatic end_test();
        $display("test %s: %0d errors", test_name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests++;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int presses;
        int extra;
        reset       = 1'b1;
        tick        = 1'b1;
        button      = '0;
        run_ticks   = 0;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        ref_preset = INIT_PRESET;
        ref_cursor = CURSOR_W'(DIGITS - 1);
        ref_count  = INIT_PRESET;

        test_name = "reset_state";
        next_sample();
        check_time("count", ref_count, count);
        check_time("preset", ref_preset, preset);
        check_cursor("cursor", ref_cursor, cursor);
        check_mode("mode", MODE_STOPPED, mode);
        check_bit("beep", 1'b0, beep);
        end_test();

        // Random walk over the preset digits
        test_name = "preset_edit";
        wait_for_mode(BTN_SET, MODE_SET, 400);
        ref_cursor = CURSOR_W'(DIGITS - 1);
        presses = 12 + random_bits(3);
        repeat (presses) begin
            case (random_bits(2))
                0:       edit_press(BTN_UP);
                1:       edit_press(BTN_DOWN);
                2:       edit_press(BTN_LEFT);
                default: edit_press(BTN_RIGHT);
            endcase
        end
        // Digit wrap 0 to 9 and cursor wrap 0 to 3
        while (ref_cursor != '0) begin
            edit_press(BTN_RIGHT);
        end
        dial_digit(0);
        edit_press(BTN_DOWN);
        edit_press(BTN_RIGHT);
        end_test();

        test_name = "exit_clear";
        wait_for_mode(BTN_EXIT, MODE_STOPPED, 400);
        check_time("count after exit", ref_count, count);
        wait_for_mode(BTN_SET, MODE_SET, 400);
        ref_cursor = CURSOR_W'(DIGITS - 1);
        check_cursor("cursor on entry", ref_cursor, cursor);
        wait_for_mode(BTN_CLEAR, MODE_STOPPED, 400);
        ref_count = ref_preset;
        check_time("count after clear", ref_count, count);
        end_test();

        // MSD of 5 keeps two long runs clear of zero
        test_name = "countdown";
        wait_for_mode(BTN_SET, MODE_SET, 400);
        ref_cursor = CURSOR_W'(DIGITS - 1);
        dial_digit(5);
        wait_for_mode(BTN_CLEAR, MODE_STOPPED, 400);
        ref_count = ref_preset;
        repeat (2) begin
            run_ticks = 0;
            wait_for_mode(BTN_RUN, MODE_RUN, 2200);
            extra = random_bits(6);
            repeat (extra) next_sample();
            wait_for_mode(BTN_RUN, MODE_STOPPED, 2200);
            @(posedge clk);
            tick <= 1'b0;
            next_sample();
            ref_count = ref_time(OP_COUNT, ref_count, 0, run_ticks);
            check_time("count after stop", ref_count, count);
            @(posedge clk);
            tick <= 1'b1;
        end
        end_test();

        // Preset 0004 with the alarm ended first by SET and then by its own timeout
        test_name = "alarm";
        wait_for_mode(BTN_SET, MODE_SET, 2200);
        ref_cursor = CURSOR_W'(DIGITS - 1);
        repeat (DIGITS - 1) begin
            dial_digit(0);
            edit_press(BTN_RIGHT);
        end
        dial_digit(4);
        wait_for_mode(BTN_CLEAR, MODE_STOPPED, 400);
        for (int pass = 0; pass < 2; pass++) begin
            wait_for_mode(BTN_RUN, MODE_RUN, 2200);
            wait_for_mode(-1, MODE_ALARM, 100);
            check_time("count at alarm", '0, count);
            check_bit("beep at alarm", 1'b1, beep);
            if (pass == 0) begin
                wait_for_mode(BTN_SET, MODE_STOPPED, 100);
            end else begin
                wait_for_mode(-1, MODE_STOPPED, WAIT_ALARM + 200);
            end
            check_mode("mode after alarm", MODE_STOPPED, mode);
            check_bit("beep after alarm", 1'b0, beep);
            check_time("count after alarm", ref_preset, count);
        end
        end_test();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/timer_pkg.sv
hw/hold_off_timer.sv
hw/bcd_preset_editor.sv
hw/bcd_down_counter.sv
hw/countdown_fsm.sv
hw/countdown_timer_top.sv
sim/countdown_timer_checker.sv
sim/countdown_timer_tb.sv
